// ==== files.f ====
logic/loader_pkg.sv
logic/mem_write_if.sv
logic/download_tracker.sv
logic/pointer_injector.sv
logic/wb_write_master.sv
logic/media_loader_top.sv
tests/wb_memory_model.sv
tests/media_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator, run it and judge the result from the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f files.f --top-module media_loader_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vmedia_loader_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// ==== tests/media_loader_tb.sv ====
// Directed loader tests; memory contents and write count are read from the model hierarchically
`timescale 1ns/1ps

module media_loader_tb;

    // Room for about 62 writes at ack delay 12 many times over
    localparam int MAX_CYCLES = 20000;
    localparam int TAP_LEN    = 16;

    logic                  clk_sys, reset;
    logic                  dl_active, dl_wr, dl_no_header, dl_busy;
    loader_pkg::dl_index_t dl_index;
    loader_pkg::file_ofs_t dl_addr;
    loader_pkg::byte_t     dl_data, wb_dat;
    loader_pkg::mem_addr_t wb_adr, tap_end;
    logic                  wb_cyc, wb_stb, wb_ack, force_reset;
    int                    max_delay;
    int                    error_count = 0;
    int                    cycle_count = 0;
    int                    force_count = 0;
    int                    data_bytes  = 0;
    int                    prg_count   = 0;

    media_loader_top media_loader_top_i (
        .clk_sys (clk_sys), .reset (reset),
        .dl_active_i (dl_active), .dl_index_i (dl_index), .dl_wr_i (dl_wr),
        .dl_addr_i (dl_addr), .dl_data_i (dl_data), .dl_no_header_i (dl_no_header),
        .dl_busy_o (dl_busy), .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat), .wb_ack_i (wb_ack), .force_reset_o (force_reset),
        .tap_end_o (tap_end)
    );

    wb_memory_model memory_model_i (
        .clk_sys (clk_sys), .reset (reset), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
        .wb_adr_i (wb_adr), .wb_dat_i (wb_dat), .wb_ack_o (wb_ack), .max_delay_i (max_delay)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        if (!reset && force_reset)
            force_count++;
    end

    always @(posedge clk_sys) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_mem_byte(input string name, input loader_pkg::mem_addr_t addr,
                                   input loader_pkg::byte_t expected);
        if (!memory_model_i.mem.exists(addr)) begin
            error_count++;
            $display("%s: no write reached address %h", name, addr);
        end else begin
            compare_values(name, 32'(expected), 32'(memory_model_i.mem[addr]));
        end
    endtask

    task automatic next_cycle;
        @(posedge clk_sys);
        #1;
    endtask

    task automatic start_download(input loader_pkg::dl_index_t idx, input logic no_hdr);
        dl_index     = idx;
        dl_no_header = no_hdr;
        next_cycle();
        dl_active = 1'b1;
        next_cycle();
    endtask

    // Byte stays on the stream until an edge sees busy low
    task automatic send_byte(input loader_pkg::file_ofs_t ofs, input loader_pkg::byte_t data);
        dl_wr   = 1'b1;
        dl_addr = ofs;
        dl_data = data;
        while (dl_busy)
            next_cycle();
        next_cycle();
        dl_wr = 1'b0;
    endtask

    // Done pulse follows the drop by one cycle and busy then covers the pointer writes
    task automatic end_download;
        dl_active = 1'b0;
        next_cycle();
        next_cycle();
        while (dl_busy || wb_cyc)
            next_cycle();
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic reset_value_test;
        compare_values("reset dl_busy", 32'(0), 32'(dl_busy));
        compare_values("reset wb_cyc", 32'(0), 32'(wb_cyc));
        compare_values("reset wb_stb", 32'(0), 32'(wb_stb));
        compare_values("reset force_reset", 32'(0), 32'(force_reset));
        compare_values("reset tap_end", 32'(loader_pkg::TAP_MEM_START), 32'(tap_end));
    endtask

    task automatic rom_download_test;
        int base;
        base = memory_model_i.write_count;
        start_download(loader_pkg::IDX_ROM, 1'b0);
        send_byte(24'h001234, 8'h11);
        send_byte(24'h004567, 8'h22);
        send_byte(24'h008ABC, 8'h33);
        send_byte(24'h00A321, 8'h44);
        // Region 110 has no target
        send_byte(24'h00C010, 8'h55);
        end_download();
        expect_mem_byte("rom drive", 22'h001234, 8'h11);
        expect_mem_byte("rom kernal", 22'(loader_pkg::ROM_BASE_KERNAL) + 22'h0567, 8'h22);
        expect_mem_byte("rom basic", 22'(loader_pkg::ROM_BASE_BASIC) + 22'h0ABC, 8'h33);
        expect_mem_byte("rom char", 22'(loader_pkg::ROM_BASE_CHAR) + 22'h0321, 8'h44);
        compare_values("rom write count", 32'(base + 4), 32'(memory_model_i.write_count));
        data_bytes += 4;
    endtask

    task automatic prg_download_test(input string name, input logic no_hdr,
                                     input loader_pkg::cpu_addr_t load, input int pulses);
        int                    forces;
        int                    ofs;
        loader_pkg::cpu_addr_t end_addr;
        forces = force_count;
        ofs    = 0;
        start_download(loader_pkg::IDX_PRG, no_hdr);
        if (!no_hdr) begin
            send_byte(24'd0, load[7:0]);
            send_byte(24'd1, load[15:8]);
            ofs = 2;
        end
        for (int i = 0; i < 5; i++)
            send_byte(24'(ofs + i), 8'(8'h60 + i));
        end_download();
        for (int i = 0; i < 5; i++)
            expect_mem_byte(name, 22'(load) + 22'(i), 8'(8'h60 + i));
        end_addr = load + 16'd5;
        for (int i = 0; i < loader_pkg::PTR_COUNT; i++)
            expect_mem_byte({name, " pointer"}, 22'(loader_pkg::PTR_ADDRS[i]),
                            i[0] ? end_addr[15:8] : end_addr[7:0]);
        compare_values({name, " reset pulses"}, 32'(pulses), 32'(force_count - forces));
        data_bytes += 5;
        prg_count++;
    endtask

    task automatic tap_download_test(input string name, input int delay);
        int base;
        base      = memory_model_i.write_count;
        max_delay = delay;
        start_download(loader_pkg::IDX_TAP, 1'b0);
        for (int i = 0; i < TAP_LEN; i++)
            send_byte(24'(i), 8'(i * 13 + delay));
        end_download();
        for (int i = 0; i < TAP_LEN; i++)
            expect_mem_byte(name, loader_pkg::TAP_MEM_START + 22'(i), 8'(i * 13 + delay));
        compare_values({name, " end"}, 32'(loader_pkg::TAP_MEM_START) + TAP_LEN, 32'(tap_end));
        compare_values({name, " write count"}, 32'(base + TAP_LEN),
                       32'(memory_model_i.write_count));
        data_bytes += TAP_LEN;
        max_delay = 3;
    endtask

    initial begin
        reset        = 1'b1;
        dl_active    = 1'b0;
        dl_wr        = 1'b0;
        dl_index     = '0;
        dl_addr      = '0;
        dl_data      = '0;
        dl_no_header = 1'b0;
        max_delay    = 3;
        repeat (8) next_cycle();
        reset_value_test();
        reset = 1'b0;
        next_cycle();
        rom_download_test();
        prg_download_test("prg header", 1'b0, 16'h1201, 0);
        prg_download_test("prg no header", 1'b1, loader_pkg::CART_BASE, 1);
        tap_download_test("tap", 3);
        tap_download_test("tap backpressure", 12);
        compare_values("total writes", 32'(data_bytes + 8 * prg_count),
                       32'(memory_model_i.write_count));
        $display("Run complete: %0d errors in %0d cycles", error_count, cycle_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== tests/wb_memory_model.sv ====
// Write-only Wishbone slave with sparse byte storage; ack delay per write is random up to max_delay_i
`timescale 1ns/1ps

module wb_memory_model (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  loader_pkg::mem_addr_t wb_adr_i,
    input  loader_pkg::byte_t     wb_dat_i,
    output logic                  wb_ack_o,
    input  int                    max_delay_i
);

    loader_pkg::byte_t mem [loader_pkg::mem_addr_t];
    int                write_count;
    int                wait_left;
    logic              delay_set_q;
    integer            seed = 90;

    always @(posedge clk_sys) begin
        if (reset) begin
            wb_ack_o    <= 1'b0;
            delay_set_q <= 1'b0;
            wait_left   <= 0;
            write_count <= 0;
        end else if (wb_ack_o) begin
            // Ack is a single-cycle pulse
            wb_ack_o    <= 1'b0;
            delay_set_q <= 1'b0;
        end else if (wb_cyc_i && wb_stb_i) begin
            if (!delay_set_q) begin
                delay_set_q <= 1'b1;
                wait_left   <= $unsigned($random(seed)) % (max_delay_i + 1);
            end else if (wait_left > 0) begin
                wait_left <= wait_left - 1;
            end else begin
                mem[wb_adr_i] = wb_dat_i;
                write_count <= write_count + 1;
                wb_ack_o    <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/media_loader_top.sv ====
// Media loader top; one clock domain, all memory writes leave through the Wishbone port
`timescale 1ns/1ps

module media_loader_top (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  dl_active_i,
    input  loader_pkg::dl_index_t dl_index_i,
    input  logic                  dl_wr_i,
    input  loader_pkg::file_ofs_t dl_addr_i,
    input  loader_pkg::byte_t     dl_data_i,
    input  logic                  dl_no_header_i,
    output logic                  dl_busy_o,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output loader_pkg::mem_addr_t wb_adr_o,
    output loader_pkg::byte_t     wb_dat_o,
    input  logic                  wb_ack_i,
    output logic                  force_reset_o,
    output loader_pkg::mem_addr_t tap_end_o
);

    logic                  trk_busy, inj_busy;
    logic                  trk_wr;
    logic                  prg_done;
    logic                  hit_cart;
    loader_pkg::cpu_addr_t load_end;

    mem_write_if dl_wr_if ();
    mem_write_if inj_wr_if ();

    // No byte is taken while the pointer sequence runs
    assign trk_wr = dl_wr_i & ~inj_busy;

    download_tracker download_tracker_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_active_i    (dl_active_i),
        .dl_index_i     (dl_index_i),
        .dl_wr_i        (trk_wr),
        .dl_addr_i      (dl_addr_i),
        .dl_data_i      (dl_data_i),
        .dl_no_header_i (dl_no_header_i),
        .busy_o         (trk_busy),
        .prg_done_o     (prg_done),
        .load_end_o     (load_end),
        .hit_cart_o     (hit_cart),
        .tap_end_o      (tap_end_o),
        .wr             (dl_wr_if.source)
    );

    pointer_injector pointer_injector_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .start_i       (prg_done),
        .load_end_i    (load_end),
        .hit_cart_i    (hit_cart),
        .busy_o        (inj_busy),
        .force_reset_o (force_reset_o),
        .wr            (inj_wr_if.source)
    );

    wb_write_master wb_write_master_i (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .dl_req   (dl_wr_if.sink),
        .inj_req  (inj_wr_if.sink),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_ack_i (wb_ack_i)
    );

    // Stream waits on a pending data write or the pointer sequence
    assign dl_busy_o = trk_busy | inj_busy;

endmodule

// ==== logic/wb_write_master.sv ====
// Write-only Wishbone classic master; one cycle at a time and no timeout on a missing ack
`timescale 1ns/1ps

module wb_write_master (
    input  logic                  clk_sys,
    input  logic                  reset,
    mem_write_if.sink             dl_req,
    mem_write_if.sink             inj_req,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output loader_pkg::mem_addr_t wb_adr_o,
    output loader_pkg::byte_t     wb_dat_o,
    input  logic                  wb_ack_i
);

    logic                  cyc_q, stb_q;
    logic                  serve_inj_q;
    logic                  dl_ack_q, inj_ack_q;
    logic                  dl_pend, inj_pend;
    loader_pkg::mem_addr_t adr_q;
    loader_pkg::byte_t     dat_q;

    // A request still high in its ack cycle is already served
    assign dl_pend  = dl_req.req & ~dl_ack_q;
    assign inj_pend = inj_req.req & ~inj_ack_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cyc_q       <= 1'b0;
            stb_q       <= 1'b0;
            serve_inj_q <= 1'b0;
            dl_ack_q    <= 1'b0;
            inj_ack_q   <= 1'b0;
        end else begin
            dl_ack_q  <= 1'b0;
            inj_ack_q <= 1'b0;
            if (cyc_q) begin
                if (wb_ack_i) begin
                    cyc_q     <= 1'b0;
                    stb_q     <= 1'b0;
                    inj_ack_q <= serve_inj_q;
                    dl_ack_q  <= ~serve_inj_q;
                end
            end else if (inj_pend || dl_pend) begin
                // Injector first
                cyc_q       <= 1'b1;
                stb_q       <= 1'b1;
                serve_inj_q <= inj_pend;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!cyc_q) begin
            adr_q <= inj_pend ? inj_req.addr : dl_req.addr;
            dat_q <= inj_pend ? inj_req.data : dl_req.data;
        end
    end

    assign wb_cyc_o    = cyc_q;
    assign wb_stb_o    = stb_q;
    assign wb_adr_o    = adr_q;
    assign wb_dat_o    = dat_q;
    assign dl_req.ack  = dl_ack_q;
    assign inj_req.ack = inj_ack_q;

    a_stb_in_cyc: assert property (@(posedge clk_sys) disable iff (reset) wb_stb_o |-> wb_cyc_o);

endmodule

// ==== logic/pointer_injector.sv ====
// Runs once per start pulse; load_end_i is sampled at start and each write waits for its ack
`timescale 1ns/1ps

module pointer_injector (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  start_i,
    input  loader_pkg::cpu_addr_t load_end_i,
    input  logic                  hit_cart_i,
    output logic                  busy_o,
    output logic                  force_reset_o,
    mem_write_if.source           wr
);

    loader_pkg::inject_state_t          state_q;
    logic [loader_pkg::PTR_IDX_W-1:0]   idx_q;
    logic                               req_q;
    logic                               force_q;
    loader_pkg::cpu_addr_t              end_q;
    loader_pkg::mem_addr_t              addr_q;
    loader_pkg::byte_t                  data_q;

    // ========================================
    // Sequencer
    // ========================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state_q <= loader_pkg::INJ_IDLE;
            idx_q   <= '0;
            req_q   <= 1'b0;
            force_q <= 1'b0;
        end else begin
            case (state_q)
                loader_pkg::INJ_IDLE: begin
                    idx_q <= '0;
                    if (start_i)
                        state_q <= loader_pkg::INJ_WRITE;
                end
                loader_pkg::INJ_WRITE: begin
                    req_q   <= 1'b1;
                    state_q <= loader_pkg::INJ_WAIT;
                end
                loader_pkg::INJ_WAIT: begin
                    if (wr.ack) begin
                        req_q   <= 1'b0;
                        state_q <= loader_pkg::INJ_NEXT;
                    end
                end
                loader_pkg::INJ_NEXT: begin
                    if (idx_q == loader_pkg::PTR_IDX_W'(loader_pkg::PTR_COUNT - 1)) begin
                        force_q <= hit_cart_i;
                        state_q <= loader_pkg::INJ_RESET;
                    end else begin
                        idx_q   <= idx_q + 1'b1;
                        state_q <= loader_pkg::INJ_WRITE;
                    end
                end
                default: begin
                    // Reset request lasts this one state
                    force_q <= 1'b0;
                    state_q <= loader_pkg::INJ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state_q == loader_pkg::INJ_IDLE && start_i)
            end_q <= load_end_i;
        if (state_q == loader_pkg::INJ_WRITE) begin
            addr_q <= loader_pkg::mem_addr_t'(loader_pkg::PTR_ADDRS[idx_q]);
            data_q <= idx_q[0] ? end_q[15:8] : end_q[7:0];
        end
    end

    assign busy_o        = (state_q != loader_pkg::INJ_IDLE) | start_i;
    assign force_reset_o = force_q;
    assign wr.req        = req_q;
    assign wr.addr       = addr_q;
    assign wr.data       = data_q;

    a_force_single: assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_o |=> !force_reset_o);

endmodule

// ==== logic/download_tracker.sv ====
// Index must be stable while dl_active_i is high; offsets above $FFFF are dropped for ROM images
`timescale 1ns/1ps

module download_tracker (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  dl_active_i,
    input  loader_pkg::dl_index_t dl_index_i,
    input  logic                  dl_wr_i,
    input  loader_pkg::file_ofs_t dl_addr_i,
    input  loader_pkg::byte_t     dl_data_i,
    input  logic                  dl_no_header_i,
    output logic                  busy_o,
    output logic                  prg_done_o,
    output loader_pkg::cpu_addr_t load_end_o,
    output logic                  hit_cart_o,
    output loader_pkg::mem_addr_t tap_end_o,
    mem_write_if.source           wr
);

    logic                  is_rom, is_prg, is_tap;
    logic                  prg_active, prg_active_q;
    logic                  take;
    logic                  rom_keep;
    logic                  prg_hdr;
    logic                  wr_en;
    logic                  req_q;
    loader_pkg::mem_addr_t rom_addr, tap_cur, wr_addr, addr_q, tap_addr_q;
    loader_pkg::cpu_addr_t prg_cur, prg_addr_q;
    loader_pkg::byte_t     data_q;

    // ========================================
    // Index decode
    // ========================================
    assign is_rom     = (dl_index_i == loader_pkg::IDX_ROM);
    assign is_prg     = (dl_index_i == loader_pkg::IDX_PRG) || (dl_index_i == loader_pkg::IDX_CRT);
    assign is_tap     = (dl_index_i == loader_pkg::IDX_TAP);
    assign prg_active = dl_active_i & is_prg;

    // Pending write blocks the stream
    assign busy_o = req_q;
    assign take   = dl_active_i & dl_wr_i & ~req_q;

    // ROM region map from offset bits 15:13
    always_comb begin
        rom_keep = (dl_addr_i[23:16] == 8'h00);
        rom_addr = '0;
        case (dl_addr_i[15:13])
            3'b000, 3'b001: rom_addr = {8'h00, dl_addr_i[13:0]};
            3'b010, 3'b011: rom_addr = loader_pkg::mem_addr_t'(
                loader_pkg::ROM_BASE_KERNAL | {3'b000, dl_addr_i[12:0]});
            3'b100:         rom_addr = loader_pkg::mem_addr_t'(
                loader_pkg::ROM_BASE_BASIC | {3'b000, dl_addr_i[12:0]});
            3'b101:         rom_addr = loader_pkg::mem_addr_t'(
                loader_pkg::ROM_BASE_CHAR | {4'h0, dl_addr_i[11:0]});
            default:        rom_keep = 1'b0;
        endcase
    end

    // First two bytes carry the load address unless headerless
    assign prg_hdr = ~dl_no_header_i && (dl_addr_i < loader_pkg::file_ofs_t'(2));
    assign prg_cur = (dl_no_header_i && dl_addr_i == '0) ? loader_pkg::CART_BASE : prg_addr_q;
    assign tap_cur = (dl_addr_i == '0) ? loader_pkg::TAP_MEM_START : tap_addr_q;

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = rom_addr;
        if (is_rom) begin
            wr_en = rom_keep;
        end else if (is_prg) begin
            wr_en   = ~prg_hdr;
            wr_addr = loader_pkg::mem_addr_t'(prg_cur);
        end else if (is_tap) begin
            wr_en   = 1'b1;
            wr_addr = tap_cur;
        end
    end

    // ========================================
    // Address tracking and request
    // ========================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            req_q        <= 1'b0;
            prg_active_q <= 1'b0;
            prg_done_o   <= 1'b0;
            hit_cart_o   <= 1'b0;
            prg_addr_q   <= '0;
            tap_addr_q   <= loader_pkg::TAP_MEM_START;
        end else begin
            prg_active_q <= prg_active;
            prg_done_o   <= prg_active_q & ~prg_active;
            if (prg_active & ~prg_active_q)
                hit_cart_o <= 1'b0;
            if (wr.ack)
                req_q <= 1'b0;
            if (take) begin
                if (wr_en)
                    req_q <= 1'b1;
                if (is_prg && prg_hdr) begin
                    if (dl_addr_i[0])
                        prg_addr_q[15:8] <= dl_data_i;
                    else
                        prg_addr_q[7:0] <= dl_data_i;
                end else if (is_prg) begin
                    prg_addr_q <= prg_cur + 16'd1;
                    if (prg_cur == loader_pkg::CART_BASE)
                        hit_cart_o <= 1'b1;
                end
                if (is_tap)
                    tap_addr_q <= tap_cur + 22'd1;
            end
        end
    end

    // Payload only moves when no request is outstanding
    always_ff @(posedge clk_sys) begin
        if (take && wr_en) begin
            addr_q <= wr_addr;
            data_q <= dl_data_i;
        end
    end

    assign wr.req     = req_q;
    assign wr.addr    = addr_q;
    assign wr.data    = data_q;
    assign load_end_o = prg_addr_q;
    assign tap_end_o  = tap_addr_q;

    // Channel payload must not move under a waiting request
    a_req_stable: assert property (@(posedge clk_sys) disable iff (reset)
        wr.req && !wr.ack |=> $stable(wr.addr) && $stable(wr.data));

endmodule

// ==== logic/mem_write_if.sv ====
// Single byte-write channel; source holds req, addr and data until a one-cycle ack
`timescale 1ns/1ps

interface mem_write_if;

    // Request side
    logic                  req;
    loader_pkg::mem_addr_t addr;
    loader_pkg::byte_t     data;

    // Completion pulse from the sink
    logic                  ack;

    modport source (
        output req,
        output addr,
        output data,
        input  ack
    );

    modport sink (
        input  req,
        input  addr,
        input  data,
        output ack
    );

endinterface

// ==== logic/loader_pkg.sv ====
// Shared loader types and constants; memory map fixed to the 22-bit home-computer layout
package loader_pkg;

    // ========================================
    // Types
    // ========================================

    // Physical memory address
    typedef logic [21:0] mem_addr_t;
    // Address as the CPU sees it
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    // Byte offset within one download
    typedef logic [23:0] file_ofs_t;
    typedef logic [7:0]  dl_index_t;

    typedef enum logic [2:0] {
        INJ_IDLE,
        INJ_WRITE,
        INJ_WAIT,
        INJ_NEXT,
        INJ_RESET
    } inject_state_t;

    // ========================================
    // Download kinds
    // ========================================
    localparam dl_index_t IDX_ROM = 8'h00;
    localparam dl_index_t IDX_PRG = 8'h01;
    localparam dl_index_t IDX_CRT = 8'h41;
    localparam dl_index_t IDX_TAP = 8'h81;

    // ========================================
    // Address map
    // ========================================
    localparam mem_addr_t TAP_MEM_START   = 22'h20000;
    // No-header target, also the auto-reset trigger
    localparam cpu_addr_t CART_BASE       = 16'hA000;
    localparam cpu_addr_t ROM_BASE_KERNAL = 16'hE000;
    localparam cpu_addr_t ROM_BASE_BASIC  = 16'hC000;
    localparam cpu_addr_t ROM_BASE_CHAR   = 16'h8000;

    // Zero-page end pointers, even entries get the low byte
    localparam int PTR_COUNT = 8;
    localparam int PTR_IDX_W = $clog2(PTR_COUNT);
    localparam cpu_addr_t PTR_ADDRS [PTR_COUNT] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

endpackage
